// File: filelist.f
+incdir+common
+incdir+verif
common/mem_system_pkg.sv
cache/cache_way.sv
cache/cache_controller.sv
design/main_memory.sv
design/mem_system.sv
verif/tb_mem_system.sv

// File: Makefile
# Verilator build and run for the cache memory system

VERILATOR ?= verilator
TOP       ?= tb_mem_system
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= SIMULATION PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := common/mem_system_defines.svh verif/tb_mem_model.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG) && echo "check: pass" || (echo "check: fail" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Word-addressed copy of what a read should return
logic [15:0]          shadow_mem [1 << 15];
logic [`TAG_BITS-1:0] model_tag [2][1 << `INDEX_BITS];
logic                 model_valid [2][1 << `INDEX_BITS];
logic                 model_dirty [2][1 << `INDEX_BITS];
logic                 model_victim;
logic [15:0]          lfsr_state;

task automatic model_reset();
	for (int a = 0; a < (1 << 15); a++) begin
		shadow_mem[a] = '0;
	end
	for (int s = 0; s < (1 << `INDEX_BITS); s++) begin
		model_valid[0][s] = 1'b0;
		model_valid[1][s] = 1'b0;
		model_dirty[0][s] = 1'b0;
		model_dirty[1][s] = 1'b0;
		model_tag[0][s]   = '0;
		model_tag[1][s]   = '0;
	end
	model_victim = 1'b0;
	lfsr_state   = 16'd73;
endtask

// x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic logic [15:0] lfsr_take(input int nbits);
	logic [15:0] val;
	logic        fb;
	val = '0;
	for (int i = 0; i < nbits; i++) begin
		fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		val        = {val[14:0], fb};
	end
	return val;
endfunction

function automatic logic model_hit(input cpu_req_t req);
	logic [`TAG_BITS-1:0]   tag;
	logic [`INDEX_BITS-1:0] idx;
	tag = req.addr[`OFFSET_BITS + `INDEX_BITS +: `TAG_BITS];
	idx = req.addr[`OFFSET_BITS +: `INDEX_BITS];
	return (model_valid[0][idx] && model_tag[0][idx] == tag) ||
		(model_valid[1][idx] && model_tag[1][idx] == tag);
endfunction

function automatic cpu_rsp_t expected_rsp(input cpu_req_t req);
	cpu_rsp_t rsp;
	rsp      = '0;
	rsp.done = 1'b1;
	if (req.addr[0]) begin
		rsp.err = 1'b1;   // Rejected in compare
	end else begin
		rsp.hit   = model_hit(req);
		rsp.stall = !model_hit(req);   // A miss completes in finish
		rsp.rdata = shadow_mem[req.addr[15:1]];
	end
	return rsp;
endfunction

// Cycles from acceptance to done: lookup, clean refill or dirty writeback
function automatic int expected_latency(input cpu_req_t req);
	logic [`INDEX_BITS-1:0] idx;
	logic                   way;
	idx = req.addr[`OFFSET_BITS +: `INDEX_BITS];
	if (req.addr[0] || model_hit(req)) begin
		return 1;
	end
	way = !model_valid[0][idx] ? 1'b0 : (!model_valid[1][idx] ? 1'b1 : ~model_victim);
	return model_dirty[way][idx] ? 13 : 9;
endfunction

task automatic update_model(input cpu_req_t req);
	logic [`INDEX_BITS-1:0] idx;
	logic [`TAG_BITS-1:0]   tag;
	logic                   way;
	logic                   hit;
	idx = req.addr[`OFFSET_BITS +: `INDEX_BITS];
	tag = req.addr[`OFFSET_BITS + `INDEX_BITS +: `TAG_BITS];
	hit = model_hit(req);
	if (!req.addr[0]) begin
		model_victim = ~model_victim;   // Flips before the miss picks a way
		if (hit) begin
			way = (model_valid[0][idx] && model_tag[0][idx] == tag) ? 1'b0 : 1'b1;
		end else begin
			way = !model_valid[0][idx] ? 1'b0 : (!model_valid[1][idx] ? 1'b1 : model_victim);
			model_tag[way][idx]   = tag;
			model_valid[way][idx] = 1'b1;
			model_dirty[way][idx] = 1'b0;
		end
		if (req.wr) begin
			shadow_mem[req.addr[15:1]] = req.wdata;
			model_dirty[way][idx]      = 1'b1;
		end
	end
endtask

`endif

// File: verif/tb_mem_system.sv
`timescale 1ns/1ps
`include "mem_system_defines.svh"

module tb_mem_system
	import mem_system_pkg::*;
();

	logic     clk;
	logic     rst_n;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;

	string    test_name;
	cpu_rsp_t exp_q [$];   // Predicted responses in issue order
	bit       data_q [$];
	string    name_q [$];
	int       checked;

	`include "tb_mem_model.svh"

	mem_system dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.cpu_req (cpu_req),
		.cpu_rsp (cpu_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	function automatic string rsp_text(input cpu_rsp_t r);
		return $sformatf("rdata=%h done=%b stall=%b hit=%b err=%b",
			r.rdata, r.done, r.stall, r.hit, r.err);
	endfunction

	task automatic check_rsp(input string name, input cpu_rsp_t exp, input cpu_rsp_t act,
		input bit with_data);
		cpu_rsp_t mask;
		mask = '1;
		if (!with_data) begin
			mask.rdata = '0;   // Writes return no data
		end
		if ((act & mask) !== (exp & mask)) begin
			fail_run($sformatf("ERR %s expected %s actual %s", name, rsp_text(exp), rsp_text(act)));
		end
	endtask

	task automatic check_err(input string name, input cpu_rsp_t exp, input cpu_rsp_t act);
		if ({act.done, act.stall, act.hit, act.err} !== {exp.done, exp.stall, exp.hit, exp.err}) begin
			fail_run($sformatf("ERR %s expected %s actual %s", name, rsp_text(exp), rsp_text(act)));
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		if (act != exp) begin
			fail_run($sformatf("ERR %s expected done after %0d cycles actual %0d cycles",
				name, exp, act));
		end
	endtask

	// Every done pulse is matched against the oldest prediction
	always @(negedge clk) begin : compare_proc
		cpu_rsp_t exp;
		bit       with_data;
		string    name;
		if (rst_n === 1'b1 && cpu_rsp.done === 1'b1) begin
			if (exp_q.size() == 0) begin
				fail_run("done pulse seen with no request outstanding");
			end else begin
				exp       = exp_q.pop_front();
				with_data = data_q.pop_front();
				name      = name_q.pop_front();
				if (exp.err) begin
					check_err(name, exp, cpu_rsp);
				end else begin
					check_rsp(name, exp, cpu_rsp, with_data);
				end
				checked++;
			end
		end
	end

	task automatic wait_done(input string what, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (cpu_rsp.done !== 1'b1 && cycles < 40);
		if (cpu_rsp.done !== 1'b1) begin
			fail_run($sformatf("%s: no done pulse within 40 cycles of the request", what));
		end
	endtask

	task automatic access(input logic [15:0] addr, input logic [15:0] wdata, input bit write);
		cpu_req_t req;
		int       lat_exp;
		int       lat_act;
		req.addr  = addr;
		req.wdata = wdata;
		req.rd    = !write;
		req.wr    = write;
		exp_q.push_back(expected_rsp(req));
		data_q.push_back(!write);
		name_q.push_back(test_name);
		lat_exp = expected_latency(req);
		update_model(req);
		@(posedge clk);
		cpu_req <= req;
		@(posedge clk);
		cpu_req.rd <= 1'b0;   // One-cycle request pulse
		cpu_req.wr <= 1'b0;
		wait_done(test_name, lat_act);
		check_latency(test_name, lat_exp, lat_act);
	endtask

	initial begin
		logic [15:0] r;
		logic [15:0] a;
		logic [15:0] d;
		rst_n     = 1'b0;
		cpu_req   = '0;
		checked   = 0;
		test_name = "reset";
		model_reset();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "idle_after_reset";
		repeat (5) begin
			@(negedge clk);
			check_rsp(test_name, '0, cpu_rsp, 1'b0);
		end

		test_name = "cold_read";
		access(16'h1230, 16'h0000, 1'b0);
		access(16'h1236, 16'h0000, 1'b0);   // Same line, other word

		test_name = "write_then_read";
		access(16'h2464, 16'hbeef, 1'b1);
		for (int w = 0; w < 4; w++) begin
			a      = 16'h2460;
			a[2:1] = 2'(w);
			access(a, 16'h0000, 1'b0);
		end

		// Three tags on one index, so one dirty line has to go
		test_name = "dirty_evict";
		for (int t = 1; t <= 3; t++) begin
			access({5'(t), 8'h55, 3'b010}, 16'ha000 + 16'(t), 1'b1);
		end
		for (int t = 1; t <= 3; t++) begin
			access({5'(t), 8'h55, 3'b010}, 16'h0000, 1'b0);
		end

		test_name = "misaligned";
		access(16'h2465, 16'h1111, 1'b1);
		access(16'h2464, 16'h0000, 1'b0);

		test_name = "random";
		for (int i = 0; i < 300; i++) begin
			r        = lfsr_take(3);
			a[15:11] = {2'b00, r[2:0]};
			r        = lfsr_take(2);
			a[10:3]  = {6'd0, r[1:0]};
			r        = lfsr_take(2);
			a[2:0]   = {r[1:0], 1'b0};
			d        = lfsr_take(16);
			r        = lfsr_take(1);
			access(a, d, r[0]);
		end

		repeat (2) @(posedge clk);
		$display("%0d responses checked", checked);
		if (exp_q.size() != 0) begin
			fail_run($sformatf("%0d predicted responses never arrived", exp_q.size()));
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// File: design/mem_system.sv
`timescale 1ns/1ps

module mem_system
	import mem_system_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  cpu_req_t cpu_req,
	output cpu_rsp_t cpu_rsp
);

	way_ctrl_t   way_ctrl;
	way_status_t status0;
	way_status_t status1;
	mem_req_t    mem_req;
	mem_rsp_t    mem_rsp;
	logic [15:0] rdata0;
	logic [15:0] rdata1;
	logic [15:0] way_rdata;
	logic [15:0] fill_data;
	logic        sel_way1;

	// Hit way during lookup, otherwise the one enabled way
	assign sel_way1  = way_ctrl.enable[1] & (~way_ctrl.enable[0] | status1.hit);
	assign way_rdata = sel_way1 ? rdata1 : rdata0;

	cache_controller ctrl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_req   (cpu_req),
		.status0   (status0),
		.status1   (status1),
		.way_rdata (way_rdata),
		.mem_rsp   (mem_rsp),
		.way_ctrl  (way_ctrl),
		.mem_req   (mem_req),
		.fill_data (fill_data),
		.rsp       (cpu_rsp)
	);

	cache_way way0_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (way_ctrl),
		.enable    (way_ctrl.enable[0]),
		.wdata     (mem_req.wdata),
		.fill_data (fill_data),
		.status    (status0),
		.rdata     (rdata0)
	);

	cache_way way1_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (way_ctrl),
		.enable    (way_ctrl.enable[1]),
		.wdata     (mem_req.wdata),
		.fill_data (fill_data),
		.status    (status1),
		.rdata     (rdata1)
	);

	main_memory mem_i (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (mem_req),
		.rsp   (mem_rsp)
	);

endmodule

// File: design/main_memory.sv
`timescale 1ns/1ps
`include "mem_system_defines.svh"

module main_memory
	import mem_system_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t req,
	output mem_rsp_t rsp
);

	localparam int BANKS      = 4;
	localparam int BANK_WORDS = 8192;
	localparam int LAT        = `MEM_READ_LATENCY;

	logic [15:0]    bank_mem [BANKS][BANK_WORDS];
	logic [1:0]     bank_sel;
	logic [12:0]    bank_addr;
	logic [LAT-1:0] rvalid_pipe;
	logic [15:0]    rdata_pipe [LAT];
	logic [1:0]     rbank_pipe [LAT];
	logic           bank_busy;

	assign bank_sel  = req.addr[2:1];   // Word in line picks the bank
	assign bank_addr = req.addr[15:3];

	initial begin
		for (int b = 0; b < BANKS; b++) begin
			for (int w = 0; w < BANK_WORDS; w++) begin
				bank_mem[b][w] = '0;
			end
		end
	end

	always @(posedge clk) begin
		if (req.wr) begin
			bank_mem[bank_sel][bank_addr] <= req.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rvalid_pipe <= '0;
		end else begin
			rvalid_pipe[0] <= req.rd;
			for (int s = 1; s < LAT; s++) begin
				rvalid_pipe[s] <= rvalid_pipe[s-1];
			end
		end
	end

	// Data is sampled at request time and carried down the pipe
	always_ff @(posedge clk) begin
		rdata_pipe[0] <= bank_mem[bank_sel][bank_addr];
		rbank_pipe[0] <= bank_sel;
		for (int s = 1; s < LAT; s++) begin
			rdata_pipe[s] <= rdata_pipe[s-1];
			rbank_pipe[s] <= rbank_pipe[s-1];
		end
	end

	assign rsp.rvalid = rvalid_pipe[LAT-1];
	assign rsp.rdata  = rdata_pipe[LAT-1];

	always_comb begin
		bank_busy = 1'b0;
		for (int s = 0; s < LAT; s++) begin
			if (rvalid_pipe[s] && rbank_pipe[s] == bank_sel) begin
				bank_busy = 1'b1;
			end
		end
	end

	a_no_wr_busy_bank: assert property (@(posedge clk) disable iff (!rst_n)
		req.wr |-> !bank_busy);

endmodule

// File: cache/cache_controller.sv
`timescale 1ns/1ps
`include "mem_system_defines.svh"

module cache_controller
	import mem_system_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  cpu_req_t    cpu_req,
	input  way_status_t status0,
	input  way_status_t status1,
	input  logic [15:0] way_rdata,
	input  mem_rsp_t    mem_rsp,
	output way_ctrl_t   way_ctrl,
	output mem_req_t    mem_req,
	output logic [15:0] fill_data,
	output cpu_rsp_t    rsp
);

	localparam int WORD_BITS = $clog2(`WORDS_PER_LINE);

	ctrl_state_e             state_q;
	ctrl_state_e             state_d;
	cpu_req_t                req_q;
	logic                    victim_q;
	logic                    way_sel_q;
	logic                    alloc_way;
	logic                    lookup_hit;
	logic                    misaligned;
	logic                    illegal_state;
	logic                    in_wb;
	logic                    in_fill;
	logic [1:0]              sel_en;
	way_status_t             sel_status;
	way_status_t             alloc_status;
	logic [`TAG_BITS-1:0]    req_tag;
	logic [`INDEX_BITS-1:0]  req_index;
	logic [WORD_BITS-1:0]    req_word;
	logic [WORD_BITS-1:0]    mem_word;
	logic [WORD_BITS-1:0]    line_word;

	assign req_tag    = req_q.addr[`OFFSET_BITS + `INDEX_BITS +: `TAG_BITS];
	assign req_index  = req_q.addr[`OFFSET_BITS +: `INDEX_BITS];
	assign req_word   = req_q.addr[1 +: WORD_BITS];
	assign misaligned = req_q.addr[0];
	assign lookup_hit = status0.hit | status1.hit;

	// Invalid way 0 first, then invalid way 1, else the victim pointer
	assign alloc_way    = !status0.valid ? 1'b0 : (!status1.valid ? 1'b1 : victim_q);
	assign alloc_status = alloc_way ? status1 : status0;
	assign sel_status   = way_sel_q ? status1 : status0;
	assign sel_en       = way_sel_q ? 2'b10 : 2'b01;

	assign in_wb         = state_q inside {st_wb0, st_wb1, st_wb2, st_wb3};
	assign in_fill       = state_q inside {st_req2_fill0, st_req3_fill1, st_fill2, st_fill3};
	assign illegal_state = !(state_q inside {[st_idle:st_finish]});
	assign fill_data     = mem_rsp.rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q   <= st_idle;
			victim_q  <= 1'b0;
			way_sel_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == st_compare && !misaligned) begin
				victim_q <= ~victim_q;   // Toggles on every real lookup
			end
			if (state_q == st_allocate) begin
				way_sel_q <= alloc_way;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == st_idle && (cpu_req.rd || cpu_req.wr)) begin
			req_q <= cpu_req;
		end
	end

	always_comb begin
		case (state_q)
			st_idle:       state_d = (cpu_req.rd || cpu_req.wr) ? st_compare : st_idle;
			st_compare:    state_d = (misaligned || lookup_hit) ? st_idle : st_allocate;
			st_allocate:   state_d = (alloc_status.valid && alloc_status.dirty) ? st_wb0 : st_req0;
			st_wb0:        state_d = st_wb1;
			st_wb1:        state_d = st_wb2;
			st_wb2:        state_d = st_wb3;
			st_wb3:        state_d = st_req0;
			st_req0:       state_d = st_req1;
			st_req1:       state_d = st_req2_fill0;
			st_req2_fill0: state_d = st_req3_fill1;
			st_req3_fill1: state_d = st_fill2;
			st_fill2:      state_d = st_fill3;
			st_fill3:      state_d = st_finish;
			st_finish:     state_d = st_idle;
			default:       state_d = st_idle;
		endcase
	end

	// Requests run two words ahead of the fills
	always_comb begin
		mem_word  = 2'd0;
		line_word = req_word;
		case (state_q)
			st_wb0:        line_word = 2'd0;
			st_wb1: begin
				mem_word  = 2'd1;
				line_word = 2'd1;
			end
			st_wb2: begin
				mem_word  = 2'd2;
				line_word = 2'd2;
			end
			st_wb3: begin
				mem_word  = 2'd3;
				line_word = 2'd3;
			end
			st_req1:       mem_word = 2'd1;
			st_req2_fill0: begin
				mem_word  = 2'd2;
				line_word = 2'd0;
			end
			st_req3_fill1: begin
				mem_word  = 2'd3;
				line_word = 2'd1;
			end
			st_fill2:      line_word = 2'd2;
			st_fill3:      line_word = 2'd3;
			default:       mem_word = 2'd0;
		endcase
	end

	always_comb begin
		way_ctrl       = '0;
		way_ctrl.index = req_index;
		way_ctrl.tag   = req_tag;
		way_ctrl.word  = line_word;
		if (state_q == st_compare) begin
			way_ctrl.comp   = 1'b1;
			way_ctrl.write  = req_q.wr;
			way_ctrl.enable = misaligned ? 2'b00 : 2'b11;
		end else if (in_wb) begin
			way_ctrl.enable = sel_en;   // Selects the read word only
		end else if (in_fill) begin
			way_ctrl.write    = mem_rsp.rvalid;
			way_ctrl.data_src = 1'b1;
			way_ctrl.enable   = sel_en;
		end else if (state_q == st_finish) begin
			way_ctrl.comp   = 1'b1;
			way_ctrl.write  = req_q.wr;   // Merge of the pending store
			way_ctrl.enable = sel_en;
		end
	end

	// wdata also carries the processor store word to the ways
	always_comb begin
		mem_req.addr  = {req_tag, req_index, mem_word, 1'b0};
		mem_req.wdata = req_q.wdata;
		mem_req.rd    = state_q inside {st_req0, st_req1, st_req2_fill0, st_req3_fill1};
		mem_req.wr    = in_wb;
		if (in_wb) begin
			mem_req.addr  = {sel_status.tag, req_index, mem_word, 1'b0};   // Victim address
			mem_req.wdata = way_rdata;
		end
	end

	always_comb begin
		rsp.rdata = way_rdata;
		rsp.done  = (state_q == st_compare && (misaligned || lookup_hit)) || state_q == st_finish;
		rsp.stall = state_q != st_idle && !(state_q == st_compare && (misaligned || lookup_hit));
		rsp.hit   = state_q == st_compare && lookup_hit && !misaligned;
		rsp.err   = (state_q == st_compare && misaligned) || illegal_state;
	end

	a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		state_q inside {[st_idle:st_finish]});

	a_mem_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_req.rd && mem_req.wr));

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.done |=> !rsp.done);

endmodule

// File: cache/cache_way.sv
`timescale 1ns/1ps
`include "mem_system_defines.svh"

module cache_way
	import mem_system_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  way_ctrl_t   ctrl,
	input  logic        enable,
	input  logic [15:0] wdata,
	input  logic [15:0] fill_data,
	output way_status_t status,
	output logic [15:0] rdata
);

	localparam int SETS = 1 << `INDEX_BITS;

	logic [`TAG_BITS-1:0] tag_arr [SETS];
	logic [SETS-1:0]      valid_arr;
	logic [SETS-1:0]      dirty_arr;
	logic [15:0]          data_arr [SETS][`WORDS_PER_LINE];

	logic                 tag_match;
	logic                 fill_en;
	logic                 store_en;
	logic [15:0]          wr_word;

	assign tag_match = tag_arr[ctrl.index] == ctrl.tag;
	assign wr_word   = ctrl.data_src ? fill_data : wdata;

	// Line fill from memory versus processor store on a tag hit
	assign fill_en  = enable & ctrl.write & ~ctrl.comp;
	assign store_en = enable & ctrl.write & ctrl.comp & status.hit;

	always_comb begin
		status.valid = valid_arr[ctrl.index];
		status.dirty = dirty_arr[ctrl.index];
		status.tag   = tag_arr[ctrl.index];
		status.hit   = status.valid & tag_match;
	end

	assign rdata = data_arr[ctrl.index][ctrl.word];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_arr <= '0;
			dirty_arr <= '0;
		end else if (fill_en) begin
			valid_arr[ctrl.index] <= 1'b1;
			dirty_arr[ctrl.index] <= 1'b0;   // Fresh line matches memory
		end else if (store_en) begin
			dirty_arr[ctrl.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en || store_en) begin
			data_arr[ctrl.index][ctrl.word] <= wr_word;
		end
		if (fill_en) begin
			tag_arr[ctrl.index] <= ctrl.tag;
		end
	end

	// Memory data must only arrive on the fill path
	a_fill_without_comp: assert property (@(posedge clk) disable iff (!rst_n)
		(enable && ctrl.write && ctrl.data_src) |-> !ctrl.comp);

endmodule

// File: common/mem_system_pkg.sv
`include "mem_system_defines.svh"

package mem_system_pkg;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        rd;
		logic        wr;
	} cpu_req_t;

	typedef struct packed {
		logic [15:0] rdata;
		logic        done;   // One-cycle completion pulse
		logic        stall;
		logic        hit;
		logic        err;
	} cpu_rsp_t;

	// Command seen by both ways, each way gates on its own enable
	typedef struct packed {
		logic [`INDEX_BITS-1:0]              index;
		logic [`TAG_BITS-1:0]                tag;
		logic [$clog2(`WORDS_PER_LINE)-1:0]  word;
		logic                                comp;
		logic                                write;
		logic                                data_src;   // 1 selects memory data
		logic [1:0]                          enable;
	} way_ctrl_t;

	typedef struct packed {
		logic                  hit;
		logic                  valid;
		logic                  dirty;
		logic [`TAG_BITS-1:0]  tag;
	} way_status_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        rd;
		logic        wr;
	} mem_req_t;

	typedef struct packed {
		logic [15:0] rdata;
		logic        rvalid;
	} mem_rsp_t;

	typedef enum logic [3:0] {
		st_idle, st_compare, st_allocate,
		st_wb0, st_wb1, st_wb2, st_wb3,
		st_req0, st_req1, st_req2_fill0, st_req3_fill1,
		st_fill2, st_fill3, st_finish
	} ctrl_state_e;

endpackage

// File: common/mem_system_defines.svh
`ifndef MEM_SYSTEM_DEFINES_SVH
`define MEM_SYSTEM_DEFINES_SVH

// Address split is {tag, index, word, byte}

`define TAG_BITS          5   // Upper address bits kept per line
`define INDEX_BITS        8   // 256 sets per way
`define OFFSET_BITS       3   // Word select plus byte bit

// Line geometry
`define WORDS_PER_LINE    4

// Main memory read path depth in cycles
`define MEM_READ_LATENCY  2

`endif
